//--- source/snes_bus_pkg.sv
package snes_bus_pkg;

  // console bus widths
  localparam int SNES_ADDR_W = 24;
  localparam int SNES_DATA_W = 8;

  // sampling history depths
  localparam int CTRL_HIST_LEN = 8;
  localparam int ADDR_HIST_LEN = 7;

  // edge patterns are matched against the oldest six stages of a control history
  localparam int EDGE_PAT_W = 6;

  // falling edge of an active-low strobe, seen in the oldest stage
  localparam logic [EDGE_PAT_W-1:0] EDGE_START_PAT = 6'b100000;

  // rising edge of an active-low strobe
  localparam logic [EDGE_PAT_W-1:0] EDGE_END_PAT = 6'b011111;

  // 4 MByte ROM window in PSRAM
  localparam logic [SNES_ADDR_W-1:0] ROM_MASK = 24'h3FFFFF;

  // 1 ms at 96 MHz
  localparam int DEAD_TIMEOUT = 96000;
  localparam int DEAD_CNT_W = $clog2(DEAD_TIMEOUT + 1);

endpackage

//--- source/psram_pkg.sv
package psram_pkg;

  // 16-bit PSRAM, word addressed
  localparam int PSRAM_ADDR_W = 23;
  localparam int PSRAM_DATA_W = 16;

  // wait count of one PSRAM access, the FSM holds ROM_CYCLE_LEN+1 cycles
  localparam int ROM_CYCLE_LEN = 7;
  localparam int MEM_DELAY_W = $clog2(ROM_CYCLE_LEN + 1);

  // memory access FSM, one-hot
  typedef enum logic [4:0] {
    IDLE    = 5'b00001,
    RD_ADDR = 5'b00010,
    RD_END  = 5'b00100,
    WR_ADDR = 5'b01000,
    WR_END  = 5'b10000
  } mem_state_t;

endpackage

//--- source/snes_bus_if.sv
`timescale 1ns/100ps

interface snes_bus_if;

  // filtered console bus
  logic [snes_bus_pkg::SNES_ADDR_W-1:0] addr;
  logic [snes_bus_pkg::SNES_DATA_W-1:0] data_in;
  logic                                 read;
  logic                                 write;
  logic                                 cpu_clk;

  // ROM decode
  logic                                 rom_hit;
  logic [snes_bus_pkg::SNES_ADDR_W-1:0] mapped_addr;

  // one-cycle event strobes
  logic                                 rd_start;
  logic                                 wr_end;
  logic                                 cycle_start;
  logic                                 pulse_end;

  // console clock watchdog
  logic                                 dead;
  logic                                 alive_strobe;

  modport sampler (
    output addr, data_in, read, write, cpu_clk, rom_hit, mapped_addr,
    output rd_start, wr_end, cycle_start, pulse_end, dead, alive_strobe
  );

  modport consumer (
    input addr, data_in, read, write, cpu_clk, rom_hit, mapped_addr,
    input rd_start, wr_end, cycle_start, pulse_end, dead, alive_strobe
  );

endinterface

//--- source/psram_req_if.sv
`timescale 1ns/100ps

interface psram_req_if;

  // microcontroller slot ownership
  logic                                 mcu_hit;
  logic                                 mcu_wr_hit;
  logic                                 mcu_we_hit;

  // captured microcontroller access
  logic [snes_bus_pkg::SNES_ADDR_W-1:0] mcu_addr;
  logic [snes_bus_pkg::SNES_DATA_W-1:0] mcu_dout;

  // PSRAM byte on the addressed lane
  logic [snes_bus_pkg::SNES_DATA_W-1:0] rd_byte;

  modport arbiter (
    output mcu_hit, mcu_wr_hit, mcu_we_hit, mcu_addr, mcu_dout,
    input  rd_byte
  );

  modport mux (
    input  mcu_hit, mcu_wr_hit, mcu_we_hit, mcu_addr, mcu_dout,
    output rd_byte
  );

endinterface

//--- source/snes_bus_sampler.sv
`timescale 1ns/100ps

module snes_bus_sampler (
  input  logic                                 CLK2,
  input  logic                                 rst_n,
  input  logic [snes_bus_pkg::SNES_ADDR_W-1:0] snes_addr_in,
  input  logic                                 snes_read_in,
  input  logic                                 snes_write_in,
  input  logic                                 snes_romsel_in,
  input  logic                                 snes_cpu_clk_in,
  input  logic [snes_bus_pkg::SNES_DATA_W-1:0] snes_data,
  snes_bus_if.sampler                          bus
);

  logic [snes_bus_pkg::CTRL_HIST_LEN-1:0] read_hist;
  logic [snes_bus_pkg::CTRL_HIST_LEN-1:0] write_hist;
  logic [snes_bus_pkg::CTRL_HIST_LEN-1:0] cpu_clk_hist;
  logic [snes_bus_pkg::CTRL_HIST_LEN-1:0] pulse_hist;
  logic [snes_bus_pkg::ADDR_HIST_LEN-1:0] romsel_hist;
  logic [snes_bus_pkg::SNES_ADDR_W-1:0]   addr_hist [snes_bus_pkg::ADDR_HIST_LEN];
  logic [snes_bus_pkg::SNES_DATA_W-1:0]   data_hist [snes_bus_pkg::ADDR_HIST_LEN];
  logic                                   pulse_in;
  logic                                   romsel_f;
  logic                                   cpu_clk_f;
  logic [snes_bus_pkg::DEAD_CNT_W-1:0]    dead_cnt;
  logic                                   dead_r;
  logic                                   alive_r;

  // bus idle, neither read nor write while the cpu clock is low
  assign pulse_in = snes_read_in & snes_write_in & ~snes_cpu_clk_in;

  //////////////////////////////
  // sampling histories
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      read_hist    <= '1;
      write_hist   <= '1;
      pulse_hist   <= '1;
      romsel_hist  <= '1;
      cpu_clk_hist <= '0;
    end else begin
      read_hist    <= {read_hist[snes_bus_pkg::CTRL_HIST_LEN-2:0], snes_read_in};
      write_hist   <= {write_hist[snes_bus_pkg::CTRL_HIST_LEN-2:0], snes_write_in};
      pulse_hist   <= {pulse_hist[snes_bus_pkg::CTRL_HIST_LEN-2:0], pulse_in};
      cpu_clk_hist <= {cpu_clk_hist[snes_bus_pkg::CTRL_HIST_LEN-2:0], snes_cpu_clk_in};
      romsel_hist  <= {romsel_hist[snes_bus_pkg::ADDR_HIST_LEN-2:0], snes_romsel_in};
    end
  end

  // address and data pipelines
  always_ff @(posedge CLK2) begin
    addr_hist[0] <= snes_addr_in;
    data_hist[0] <= snes_data;
    for (int i = 1; i < snes_bus_pkg::ADDR_HIST_LEN; i++) begin
      addr_hist[i] <= addr_hist[i-1];
      data_hist[i] <= data_hist[i-1];
    end
  end

  // glitch filter, a low needs only one stage, a high needs two
  assign bus.read    = read_hist[2] & read_hist[1];
  assign bus.write   = write_hist[2] & write_hist[1];
  assign cpu_clk_f   = cpu_clk_hist[2] & cpu_clk_hist[1];
  assign bus.cpu_clk = cpu_clk_f;

  // address side lags by 5 so it settles before the strobes are used
  assign bus.addr    = addr_hist[5] & addr_hist[4];
  assign bus.data_in = data_hist[5] & data_hist[4];
  assign romsel_f    = romsel_hist[5] & romsel_hist[4];

  //////////////////////////////
  // edge strobes
  //////////////////////////////

  assign bus.rd_start    = (read_hist[7:2] == snes_bus_pkg::EDGE_START_PAT);
  assign bus.wr_end      = (write_hist[7:2] == snes_bus_pkg::EDGE_END_PAT);
  assign bus.cycle_start = (cpu_clk_hist[7:2] == snes_bus_pkg::EDGE_END_PAT);
  assign bus.pulse_end   = (pulse_hist[7:2] == snes_bus_pkg::EDGE_END_PAT);

  // ROM decode
  assign bus.rom_hit     = ~romsel_f;
  assign bus.mapped_addr = bus.addr & snes_bus_pkg::ROM_MASK;

  //////////////////////////////
  // console dead detection
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      dead_cnt <= '0;
      dead_r   <= 1'b1;
      alive_r  <= 1'b0;
    end else begin
      alive_r <= 1'b0;
      if (cpu_clk_f) begin
        dead_cnt <= '0;
        dead_r   <= 1'b0;
        // first clock after a dead period
        alive_r  <= dead_r;
      end else if (dead_cnt == snes_bus_pkg::DEAD_CNT_W'(snes_bus_pkg::DEAD_TIMEOUT)) begin
        dead_r <= 1'b1;
      end else begin
        dead_cnt <= dead_cnt + 1'b1;
      end
    end
  end

  assign bus.dead         = dead_r;
  assign bus.alive_strobe = alive_r;

endmodule

//--- source/psram_arbiter.sv
`timescale 1ns/100ps

module psram_arbiter (
  input  logic                                 CLK2,
  input  logic                                 rst_n,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [snes_bus_pkg::SNES_ADDR_W-1:0] paddr,
  input  logic [snes_bus_pkg::SNES_DATA_W-1:0] pwdata,
  output logic [snes_bus_pkg::SNES_DATA_W-1:0] prdata,
  output logic                                 pready,
  snes_bus_if.consumer                         bus,
  psram_req_if.arbiter                         req
);

  psram_pkg::mem_state_t                state;
  logic [psram_pkg::MEM_DELAY_W-1:0]    delay;
  logic                                 rd_pend;
  logic                                 wr_pend;
  logic                                 setup;
  logic                                 done;
  logic                                 free_strobe;
  logic                                 free_slot;
  logic                                 rd_hit;
  logic                                 wr_hit;
  logic [snes_bus_pkg::SNES_ADDR_W-1:0] addr_r;
  logic [snes_bus_pkg::SNES_DATA_W-1:0] dout_r;

  //////////////////////////////
  // APB slave
  //////////////////////////////

  assign setup = psel & ~penable;
  assign done  = (state == psram_pkg::RD_END) | (state == psram_pkg::WR_END);

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      pready  <= 1'b1;
    end else if (setup) begin
      rd_pend <= ~pwrite;
      wr_pend <= pwrite;
      pready  <= 1'b0;
    end else if (done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      pready  <= 1'b1;
    end
  end

  // access captured in the setup phase
  always_ff @(posedge CLK2) begin
    if (setup) begin
      addr_r <= paddr;
      dout_r <= pwdata;
    end
  end

  // cpu cycle that does not touch ROM leaves the PSRAM free
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= bus.cycle_start & ~bus.rom_hit;
    end
  end

  assign free_slot = bus.pulse_end | free_strobe | bus.dead;

  //////////////////////////////
  // memory access FSM
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state <= psram_pkg::IDLE;
      delay <= '0;
    end else if (bus.alive_strobe) begin
      // console woke up mid access, retry in a proper slot
      state <= psram_pkg::IDLE;
    end else begin
      case (state)
        psram_pkg::IDLE: begin
          delay <= psram_pkg::MEM_DELAY_W'(psram_pkg::ROM_CYCLE_LEN);
          if (free_slot && rd_pend) begin
            state <= psram_pkg::RD_ADDR;
          end else if (free_slot && wr_pend) begin
            state <= psram_pkg::WR_ADDR;
          end
        end
        psram_pkg::RD_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= psram_pkg::RD_END;
          end
        end
        psram_pkg::WR_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= psram_pkg::WR_END;
          end
        end
        default: begin
          state <= psram_pkg::IDLE;
        end
      endcase
    end
  end

  // last sample of the read window holds the settled byte
  always_ff @(posedge CLK2) begin
    if (state == psram_pkg::RD_ADDR) begin
      prdata <= req.rd_byte;
    end
  end

  assign rd_hit = (state == psram_pkg::RD_ADDR) | (state == psram_pkg::RD_END);
  assign wr_hit = (state == psram_pkg::WR_ADDR) | (state == psram_pkg::WR_END);

  assign req.mcu_hit    = rd_hit | wr_hit;
  assign req.mcu_wr_hit = wr_hit;
  assign req.mcu_we_hit = (state == psram_pkg::WR_ADDR);
  assign req.mcu_addr   = addr_r;
  assign req.mcu_dout   = dout_r;

endmodule

//--- source/psram_port_mux.sv
`timescale 1ns/100ps

module psram_port_mux (
  snes_bus_if.consumer                          bus,
  psram_req_if.mux                              req,
  output logic [psram_pkg::PSRAM_ADDR_W-1:0]    rom_addr,
  inout  wire  [psram_pkg::PSRAM_DATA_W-1:0]    rom_data,
  output logic                                  rom_oe,
  output logic                                  rom_we,
  output logic                                  rom_bhe,
  output logic                                  rom_ble,
  inout  wire  [snes_bus_pkg::SNES_DATA_W-1:0]  snes_data,
  output logic                                  snes_databus_oe,
  output logic                                  snes_databus_dir
);

  logic [snes_bus_pkg::SNES_ADDR_W-1:0] addr_sel;
  logic                                 lane_lo;
  logic                                 snes_drive;

  // microcontroller owns the PSRAM only inside its slot
  assign addr_sel = req.mcu_hit ? req.mcu_addr : bus.mapped_addr;
  assign rom_addr = addr_sel[snes_bus_pkg::SNES_ADDR_W-1:1];

  // odd byte address sits in the low lane
  assign lane_lo = addr_sel[0];
  assign rom_bhe = lane_lo;
  assign rom_ble = ~lane_lo;

  //////////////////////////////
  // PSRAM data and write enable
  //////////////////////////////

  assign rom_data[snes_bus_pkg::SNES_DATA_W-1:0] =
    (req.mcu_wr_hit & lane_lo) ? req.mcu_dout : 'z;
  assign rom_data[psram_pkg::PSRAM_DATA_W-1:snes_bus_pkg::SNES_DATA_W] =
    (req.mcu_wr_hit & ~lane_lo) ? req.mcu_dout : 'z;

  assign req.rd_byte = lane_lo ? rom_data[snes_bus_pkg::SNES_DATA_W-1:0]
                               : rom_data[psram_pkg::PSRAM_DATA_W-1:snes_bus_pkg::SNES_DATA_W];

  // output enable stays on, WE overrides it
  assign rom_oe = 1'b0;
  assign rom_we = ~req.mcu_we_hit;

  //////////////////////////////
  // console data bus
  //////////////////////////////

  // ROM read, never while the console also drives a write
  assign snes_drive = bus.rom_hit & ~bus.read & bus.write;

  assign snes_data        = snes_drive ? req.rd_byte : 'z;
  assign snes_databus_oe  = ~snes_drive;
  // level shifter towards the console while it reads
  assign snes_databus_dir = ~bus.read;

endmodule

//--- source/cart_main.sv
`timescale 1ns/100ps

module cart_main (
  input  logic                                 CLK2,
  input  logic                                 rst_n,
  // console bus
  input  logic [snes_bus_pkg::SNES_ADDR_W-1:0] snes_addr_in,
  input  logic                                 snes_read_in,
  input  logic                                 snes_write_in,
  input  logic                                 snes_romsel_in,
  input  logic                                 snes_cpu_clk_in,
  inout  wire  [snes_bus_pkg::SNES_DATA_W-1:0] snes_data,
  output logic                                 snes_databus_oe,
  output logic                                 snes_databus_dir,
  // PSRAM
  output logic [psram_pkg::PSRAM_ADDR_W-1:0]   rom_addr,
  inout  wire  [psram_pkg::PSRAM_DATA_W-1:0]   rom_data,
  output logic                                 rom_oe,
  output logic                                 rom_we,
  output logic                                 rom_bhe,
  output logic                                 rom_ble,
  // microcontroller APB
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [snes_bus_pkg::SNES_ADDR_W-1:0] paddr,
  input  logic [snes_bus_pkg::SNES_DATA_W-1:0] pwdata,
  output logic [snes_bus_pkg::SNES_DATA_W-1:0] prdata,
  output logic                                 pready
);

  snes_bus_if  i_bus ();
  psram_req_if i_req ();

  snes_bus_sampler i_sampler (
    .CLK2            (CLK2),
    .rst_n           (rst_n),
    .snes_addr_in    (snes_addr_in),
    .snes_read_in    (snes_read_in),
    .snes_write_in   (snes_write_in),
    .snes_romsel_in  (snes_romsel_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .snes_data       (snes_data),
    .bus             (i_bus.sampler)
  );

  psram_arbiter i_arbiter (
    .CLK2    (CLK2),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .bus     (i_bus.consumer),
    .req     (i_req.arbiter)
  );

  psram_port_mux i_port_mux (
    .bus              (i_bus.consumer),
    .req              (i_req.mux),
    .rom_addr         (rom_addr),
    .rom_data         (rom_data),
    .rom_oe           (rom_oe),
    .rom_we           (rom_we),
    .rom_bhe          (rom_bhe),
    .rom_ble          (rom_ble),
    .snes_data        (snes_data),
    .snes_databus_oe  (snes_databus_oe),
    .snes_databus_dir (snes_databus_dir)
  );

endmodule

//--- testbench/cart_main_chk.sv
`timescale 1ns/100ps

module cart_main_chk (
  input logic CLK2,
  input logic rst_n,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input logic pready,
  input logic rom_we,
  input logic snes_read_in,
  input logic snes_write_in,
  input logic snes_romsel_in,
  input logic snes_databus_oe,
  input logic snes_databus_dir,
  input logic dead,
  input logic rom_hit,
  input logic read,
  input logic mcu_hit
);

  // number of assertion failures so far
  int fail_cnt = 0;

  // pin levels over the sampler latency, newest in bit 0
  logic [6:0] romsel_q;
  logic [6:0] rom_read_q;

  always_ff @(posedge CLK2) begin
    romsel_q   <= {romsel_q[5:0], snes_romsel_in};
    rom_read_q <= {rom_read_q[5:0], ~snes_romsel_in & ~snes_read_in & snes_write_in};
  end

  //////////////////////////////
  // APB rules
  //////////////////////////////

  // PSRAM is always free while the console is dead
  a_dead_latency: assert property (@(posedge CLK2) disable iff (!rst_n)
    (psel && !penable && dead) |-> ##[1:12] pready)
  else begin
    fail_cnt++;
    $error("APB access with dead console took longer than 12 cycles");
  end

  a_pready_low: assert property (@(posedge CLK2) disable iff (!rst_n)
    (psel && !penable) |=> !pready)
  else begin
    fail_cnt++;
    $error("pready high in the first access phase cycle");
  end

  // pready only comes back to end an access phase
  a_pready_rise: assert property (@(posedge CLK2) disable iff (!rst_n)
    $rose(pready) |-> (psel && penable))
  else begin
    fail_cnt++;
    $error("pready rose outside an access phase");
  end

  //////////////////////////////
  // PSRAM and console bus
  //////////////////////////////

  a_we_window: assert property (@(posedge CLK2) disable iff (!rst_n)
    !rom_we |-> (psel && penable && pwrite))
  else begin
    fail_cnt++;
    $error("rom_we low outside an APB write access phase");
  end

  // ROM read held on the pins for the whole sampler latency
  a_rom_read_bus: assert property (@(posedge CLK2) disable iff (!rst_n)
    (&rom_read_q) |-> (!snes_databus_oe && snes_databus_dir))
  else begin
    fail_cnt++;
    $error("console data bus not enabled towards the console on a ROM read");
  end

  a_romsel_idle: assert property (@(posedge CLK2) disable iff (!rst_n)
    (&romsel_q) |-> snes_databus_oe)
  else begin
    fail_cnt++;
    $error("console data bus enabled while ROMSEL is high");
  end

  a_slot_free: assert property (@(posedge CLK2) disable iff (!rst_n)
    (rom_hit && !read) |-> !mcu_hit)
  else begin
    fail_cnt++;
    $error("microcontroller owns the PSRAM during a console ROM read");
  end

endmodule

bind cart_main cart_main_chk i_chk (
  .CLK2             (CLK2),
  .rst_n            (rst_n),
  .psel             (psel),
  .penable          (penable),
  .pwrite           (pwrite),
  .pready           (pready),
  .rom_we           (rom_we),
  .snes_read_in     (snes_read_in),
  .snes_write_in    (snes_write_in),
  .snes_romsel_in   (snes_romsel_in),
  .snes_databus_oe  (snes_databus_oe),
  .snes_databus_dir (snes_databus_dir),
  .dead             (i_bus.dead),
  .rom_hit          (i_bus.rom_hit),
  .read             (i_bus.read),
  .mcu_hit          (i_req.mcu_hit)
);

//--- testbench/tb_cart_main.sv
`timescale 1ns/100ps

module tb_cart_main;

  localparam int CON_LOW       = 18;
  localparam int CON_HIGH      = 8;
  localparam int APB_LIMIT     = 40;
  localparam int ACTIVE_LIMIT  = 200;
  localparam int RECOVER_LIMIT = snes_bus_pkg::DEAD_TIMEOUT + 200;
  localparam int CON_LIMIT     = 64;
  // model covers the ROM window only
  localparam int MODEL_AW      = 21;

  logic        CLK2;
  logic        rst_n;
  logic [23:0] snes_addr_in;
  logic        snes_read_in;
  logic        snes_write_in;
  logic        snes_romsel_in;
  logic        snes_cpu_clk_in;
  wire  [7:0]  snes_data;
  logic        snes_databus_oe;
  logic        snes_databus_dir;
  logic [22:0] rom_addr;
  wire  [15:0] rom_data;
  logic        rom_oe;
  logic        rom_we;
  logic        rom_bhe;
  logic        rom_ble;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [23:0] paddr;
  logic [7:0]  pwdata;
  logic [7:0]  prdata;
  logic        pready;

  logic [15:0] psram_mem [0:(1<<MODEL_AW)-1];
  logic        we_q = 1'b0;
  logic [7:0]  written [logic [23:0]];
  int unsigned lcg_state = 32'd8016;
  int          errors = 0;
  int          err_mark = 0;
  int          chk_mark = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  cart_main i_cart_main (.*);

  initial begin
    CLK2 = 1'b0;
    forever #10 CLK2 = ~CLK2;
  end

  //////////////////////////////
  // PSRAM model
  //////////////////////////////

  function automatic logic [15:0] fill_word(input logic [22:0] wa);
    return wa[15:0] ^ {wa[6:0], wa[22:14]} ^ 16'h5A3C;
  endfunction

  initial begin
    for (int i = 0; i < (1 << MODEL_AW); i++) begin
      psram_mem[i] = fill_word(23'(i));
    end
  end

  // lanes are active low
  always @(posedge CLK2) begin
    we_q <= rom_we;
    if (!rom_we) begin
      if (!rom_ble) psram_mem[rom_addr[MODEL_AW-1:0]][7:0] <= rom_data[7:0];
      if (!rom_bhe) psram_mem[rom_addr[MODEL_AW-1:0]][15:8] <= rom_data[15:8];
    end
  end

  // bus turns around one cycle after a write
  assign rom_data = (!rom_oe && rom_we && we_q) ? psram_mem[rom_addr[MODEL_AW-1:0]] : 'z;

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [23:0] rand_addr();
    return 24'(lcg_next()) & snes_bus_pkg::ROM_MASK;
  endfunction

  // odd byte address sits in the low lane
  function automatic logic [7:0] exp_byte(input logic [23:0] a);
    logic [23:0] ma;
    logic [15:0] w;
    ma = a & snes_bus_pkg::ROM_MASK;
    if (written.exists(ma)) return written[ma];
    w = fill_word(23'(ma >> 1));
    return ma[0] ? w[7:0] : w[15:8];
  endfunction

  task automatic timeout_fail(input string what);
    $display("timeout while waiting for %s", what);
    $display("Finished with errors");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
    assert (act === exp) else begin
      errors++;
      $display("[ERROR] %s expected %04h actual %04h", name, exp, act);
    end
  endtask

  task automatic finish_test(input string name);
    int chk;
    chk = i_cart_main.i_chk.fail_cnt - chk_mark;
    tests_run++;
    if (errors != err_mark || chk != 0) begin
      tests_failed++;
      $display("test %s: failed, %0d value errors, %0d assertion failures",
               name, errors - err_mark, chk);
    end else begin
      $display("test %s: passed", name);
    end
    err_mark = errors;
    chk_mark = i_cart_main.i_chk.fail_cnt;
  endtask

  task automatic apb_access(input logic wr, input logic [23:0] a, input logic [7:0] d,
                            input int limit, output logic [7:0] rd);
    int n;
    @(posedge CLK2);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= a;
    pwdata  <= d;
    @(posedge CLK2);
    penable <= 1'b1;
    n = 0;
    do begin
      @(posedge CLK2);
      n++;
      if (n > limit) timeout_fail("pready on an APB transfer");
    end while (!pready);
    rd = prdata;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // one console read cycle with a low phase and then a high phase that asserts read
  task automatic bus_cycle(input logic [23:0] a, input logic rom,
                           output logic [7:0] sample, output logic oe);
    snes_cpu_clk_in <= 1'b0;
    snes_read_in    <= 1'b1;
    snes_addr_in    <= a;
    snes_romsel_in  <= ~rom;
    repeat (CON_LOW) @(posedge CLK2);
    snes_cpu_clk_in <= 1'b1;
    snes_read_in    <= 1'b0;
    repeat (CON_HIGH) @(posedge CLK2);
    sample = snes_data;
    oe     = snes_databus_oe;
  endtask

  task automatic stop_console();
    snes_cpu_clk_in <= 1'b0;
    snes_read_in    <= 1'b1;
    snes_romsel_in  <= 1'b1;
  endtask

  task automatic read_and_check(input string name, input logic [23:0] a, input logic rom);
    logic [7:0] sample;
    logic       oe;
    bus_cycle(a, rom, sample, oe);
    if (rom) begin
      check_value(name, 16'(exp_byte(a)), 16'(sample));
    end else begin
      check_value(name, 16'h0001, 16'(oe));
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    logic [23:0] a;
    logic [7:0]  d;
    logic [7:0]  rd;
    logic        apb_done;
    rst_n           = 1'b0;
    snes_addr_in    = '0;
    snes_read_in    = 1'b1;
    snes_write_in   = 1'b1;
    snes_romsel_in  = 1'b1;
    snes_cpu_clk_in = 1'b0;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    paddr           = '0;
    pwdata          = '0;
    repeat (10) @(posedge CLK2);
    rst_n <= 1'b1;
    @(posedge CLK2);

    // console is dead after reset
    a = rand_addr();
    d = 8'(lcg_next());
    apb_access(1'b1, a, d, APB_LIMIT, rd);
    written[a] = d;
    apb_access(1'b0, a, 8'h00, APB_LIMIT, rd);
    check_value("apb_rw_dead", 16'(exp_byte(a)), 16'(rd));
    finish_test("apb_rw_dead");

    // write one lane and read back both
    for (int i = 0; i < 4; i++) begin
      a = rand_addr();
      d = 8'(lcg_next());
      apb_access(1'b1, a, d, APB_LIMIT, rd);
      written[a] = d;
      apb_access(1'b0, a ^ 24'h1, 8'h00, APB_LIMIT, rd);
      check_value("apb_latency_dead", 16'(exp_byte(a ^ 24'h1)), 16'(rd));
      apb_access(1'b0, a, 8'h00, APB_LIMIT, rd);
      check_value("apb_latency_dead", 16'(exp_byte(a)), 16'(rd));
    end
    finish_test("apb_latency_dead");

    a = rand_addr();
    d = 8'(lcg_next());
    apb_access(1'b1, a, d, APB_LIMIT, rd);
    written[a] = d;
    read_and_check("console_rom_read", a, 1'b1);
    read_and_check("console_rom_read", a ^ 24'h1, 1'b1);
    read_and_check("console_rom_read", rand_addr(), 1'b1);
    read_and_check("console_rom_read", rand_addr(), 1'b0);
    // bits above the ROM mask are ignored
    read_and_check("console_rom_read", a | 24'hC00000, 1'b1);
    finish_test("console_rom_read");

    apb_done = 1'b0;
    a = rand_addr();
    d = 8'(lcg_next());
    fork
      begin
        apb_access(1'b1, a, d, ACTIVE_LIMIT, rd);
        written[a] = d;
        apb_access(1'b0, a, 8'h00, ACTIVE_LIMIT, rd);
        check_value("apb_rw_active", 16'(exp_byte(a)), 16'(rd));
        apb_done = 1'b1;
      end
      begin
        int          n;
        int unsigned r;
        n = 0;
        while (!apb_done) begin
          r = lcg_next();
          read_and_check("apb_rw_active", rand_addr(), r[4]);
          n++;
          if (n > CON_LIMIT) timeout_fail("APB transfers with an active console");
        end
      end
    join
    finish_test("apb_rw_active");

    // hold the console clock low so only the dead slot can serve the write
    stop_console();
    repeat (20) @(posedge CLK2);
    a = rand_addr();
    d = 8'(lcg_next());
    apb_access(1'b1, a, d, RECOVER_LIMIT, rd);
    written[a] = d;
    read_and_check("dead_recovery", a, 1'b1);
    read_and_check("dead_recovery", a ^ 24'h1, 1'b1);
    read_and_check("dead_recovery", a, 1'b1);
    stop_console();
    repeat (20) @(posedge CLK2);
    finish_test("dead_recovery");

    $display("tests %0d, failed %0d, value errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, i_cart_main.i_chk.fail_cnt);
    if (errors == 0 && i_cart_main.i_chk.fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- tb.f
source/snes_bus_pkg.sv
source/psram_pkg.sv
source/snes_bus_if.sv
source/psram_req_if.sv
source/snes_bus_sampler.sv
source/psram_arbiter.sv
source/psram_port_mux.sv
source/cart_main.sv
testbench/cart_main_chk.sv
testbench/tb_cart_main.sv

//--- Bender.yml
package:
  name: cart_main

sources:
  - files:
      - source/snes_bus_pkg.sv
      - source/psram_pkg.sv
      - source/snes_bus_if.sv
      - source/psram_req_if.sv
      - source/snes_bus_sampler.sv
      - source/psram_arbiter.sv
      - source/psram_port_mux.sv
      - source/cart_main.sv
  - target: simulation
    files:
      - testbench/cart_main_chk.sv
      - testbench/tb_cart_main.sv
